/* bench/testPrograms.svh */
// test program table, one entry per index across the arrays below
// words are hand-assembled RV32I, halt is jal x0,0 (0000006f)
localparam int progCount = 5;
localparam int maxWords  = 10;
localparam int maxChecks = 8;

string progName[progCount] = '{
    "dependent alu ops",
    "load use",
    "beq taken and not taken",
    "x0 writes",
    "jal link"
};

int progLen[progCount] = '{10, 8, 10, 7, 6};

logic[31:0] progWords[progCount][maxWords] = '{
    // addi x1,x0,5  addi x2,x1,3  add x3,x1,x2  sub x4,x3,x1  and x5,x4,x3
    // or x6,x5,x1  slt x7,x4,x3  addi x8,x0,-3  slt x9,x8,x1  halt
    '{32'h00500093, 32'h00308113, 32'h002081b3, 32'h40118233, 32'h003272b3,
      32'h0012e333, 32'h003223b3, 32'hffd00413, 32'h001424b3, 32'h0000006f},
    // addi x1,x0,42  addi x2,x0,8  sw x1,4(x2)  lw x3,4(x2)  add x4,x3,x2
    // lw x5,4(x2)  add x6,x1,x5  halt
    '{32'h02a00093, 32'h00800113, 32'h00112223, 32'h00412183, 32'h00218233,
      32'h00412283, 32'h00508333, 32'h0000006f, 32'h00000000, 32'h00000000},
    // addi x1,x0,7  addi x2,x0,7  beq x1,x2,+12  addi x3,x0,1  addi x4,x0,1
    // addi x5,x0,9  beq x1,x5,+12  addi x6,x0,2  addi x7,x0,3  halt
    '{32'h00700093, 32'h00700113, 32'h00208663, 32'h00100193, 32'h00100213,
      32'h00900293, 32'h00508663, 32'h00200313, 32'h00300393, 32'h0000006f},
    // addi x0,x0,5  add x1,x0,x0  addi x2,x0,3  add x0,x2,x2  add x3,x0,x2
    // add x4,x2,x0  halt
    '{32'h00500013, 32'h000000b3, 32'h00300113, 32'h00210033, 32'h002001b3,
      32'h00010233, 32'h0000006f, 32'h00000000, 32'h00000000, 32'h00000000},
    // addi x1,x0,1  jal x2,+12  addi x3,x0,5  addi x4,x0,6  add x5,x2,x1  halt
    '{32'h00100093, 32'h00c0016f, 32'h00500193, 32'h00600213, 32'h001102b3,
      32'h0000006f, 32'h00000000, 32'h00000000, 32'h00000000, 32'h00000000}
};

int checkCount[progCount] = '{8, 4, 6, 5, 5};

int checkReg[progCount][maxChecks] = '{
    '{2, 3, 4, 5, 6, 7, 8, 9},
    '{3, 4, 5, 6, 0, 0, 0, 0},
    '{1, 3, 4, 5, 6, 7, 0, 0},
    '{0, 1, 2, 3, 4, 0, 0, 0},
    '{1, 2, 3, 4, 5, 0, 0, 0}
};

// values from plain sequential execution
logic[31:0] checkVal[progCount][maxChecks] = '{
    '{32'd8, 32'd13, 32'd8, 32'd8, 32'd13, 32'd1, 32'hfffffffd, 32'd1},
    '{32'd42, 32'd50, 32'd42, 32'd84, 32'd0, 32'd0, 32'd0, 32'd0},
    '{32'd7, 32'd0, 32'd0, 32'd9, 32'd2, 32'd3, 32'd0, 32'd0},
    '{32'd0, 32'd0, 32'd3, 32'd3, 32'd3, 32'd0, 32'd0, 32'd0},
    '{32'd1, 32'd8, 32'd0, 32'd0, 32'd9, 32'd0, 32'd0, 32'd0}
};

/* bench/cpuTopTb.sv */
`timescale 1ns/1ps

module cpuTopTb;
    logic       clk;
    logic       reset;
    logic       progValid;
    logic       progReady;
    logic[5:0]  progAddr;
    logic[31:0] progData;
    logic       start;
    logic       halted;
    logic[4:0]  dbgAddr;
    logic[31:0] dbgData;

    int errorCount;
    int timeoutCount;

    `include "testPrograms.svh"

    cpuTop cpuTop_i (
        .clk       (clk),
        .reset     (reset),
        .progValid (progValid),
        .progReady (progReady),
        .progAddr  (progAddr),
        .progData  (progData),
        .start     (start),
        .halted    (halted),
        .dbgAddr   (dbgAddr),
        .dbgData   (dbgData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkValue(input logic[31:0] actual, input logic[31:0] expected,
                              input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0t ns: %s got %08h, expected %08h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic reportTimeout(input string what);
        timeoutCount++;
        $display("timeout at %0t ns: gave up waiting for %s", $time, what);
    endtask

    task automatic applyReset();
        @(negedge clk);
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
    endtask

    // one word over the valid/ready port, taken on the rising edge with ready high
    task automatic writeWord(input int addr, input logic[31:0] data, output bit ok);
        int waitCycles;
        ok        = 1'b1;
        progValid = 1'b1;
        progAddr  = addr[5:0];
        progData  = data;
        waitCycles = 0;
        while (!progReady && ok) begin
            if (waitCycles == 50) begin
                reportTimeout("progReady during program load");
                ok = 1'b0;
            end else begin
                @(negedge clk);
                waitCycles++;
            end
        end
        if (ok)
            @(negedge clk);
        progValid = 1'b0;
    endtask

    // ready must stay low the whole run while a write is held pending
    task automatic waitForHalt(output bit ok);
        int waitCycles;
        ok = 1'b1;
        waitCycles = 0;
        while (!halted && ok) begin
            checkValue(progReady, 1'b0, "progReady while running");
            if (waitCycles == 2000) begin
                reportTimeout("halted");
                ok = 1'b0;
            end else begin
                @(negedge clk);
                waitCycles++;
            end
        end
    endtask

    task automatic runProgram(input int p);
        bit ok;
        int waitCycles;
        ok = 1'b1;
        applyReset();
        checkValue(progReady, 1'b1, "progReady after reset");
        checkValue(halted, 1'b0, "halted after reset");
        for (int w = 0; w < progLen[p] && ok; w++)
            writeWord(w, progWords[p][w], ok);
        if (ok) begin
            start = 1'b1;
            @(negedge clk);
            start     = 1'b0;
            progValid = 1'b1;  // offered mid-run, must wait for the halt
            progAddr  = 6'd63;
            progData  = 32'h0000006f;
            waitForHalt(ok);
        end
        waitCycles = 0;
        while (!progReady && ok) begin
            if (waitCycles == 10) begin
                reportTimeout("progReady after halt");
                ok = 1'b0;
            end else begin
                @(negedge clk);
                waitCycles++;
            end
        end
        if (ok)
            @(negedge clk);  // pending write taken here
        progValid = 1'b0;
        if (ok) begin
            for (int c = 0; c < checkCount[p]; c++) begin
                dbgAddr = checkReg[p][c][4:0];
                @(posedge clk);
                checkValue(dbgData, checkVal[p][c],
                           $sformatf("%s x%0d", progName[p], checkReg[p][c]));
                @(negedge clk);
            end
            checkValue(halted, 1'b1, "halted held until reset");
        end
    endtask

    initial begin
        reset        = 1'b1;
        progValid    = 1'b0;
        progAddr     = '0;
        progData     = '0;
        start        = 1'b0;
        dbgAddr      = '0;
        errorCount   = 0;
        timeoutCount = 0;

        for (int p = 0; p < progCount && timeoutCount == 0; p++)
            runProgram(p);

        $display("done: %0d value errors, %0d timeouts", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* project.f */
+incdir+bench
rtl/cpuCfgPkg.sv
rtl/rvIsaPkg.sv
rtl/hazardIf.sv
rtl/hazardUnit.sv
rtl/regFile.sv
rtl/instrDecoder.sv
rtl/aluUnit.sv
rtl/programStore.sv
rtl/pipelineCore.sv
rtl/cpuTop.sv
bench/cpuTopTb.sv

/* rtl/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  logic[cpuCfgPkg::dataWidth-1:0]  a,
    input  logic[cpuCfgPkg::dataWidth-1:0]  b,
    input  rvIsaPkg::aluOp                  ctl,
    output logic[cpuCfgPkg::dataWidth-1:0]  y,
    output logic                            zero
);
    always_comb begin
        case (ctl)
            rvIsaPkg::aluSub: y = a - b;
            rvIsaPkg::aluAnd: y = a & b;
            rvIsaPkg::aluOr:  y = a | b;
            rvIsaPkg::aluSlt: y = {{(cpuCfgPkg::dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
            default:          y = a + b;
        endcase
    end

    // beq compares via sub
    assign zero = (y == '0);

endmodule

/* rtl/cpuCfgPkg.sv */
package cpuCfgPkg;

    // data path
    localparam int dataWidth    = 32;
    localparam int regCount     = 32;
    localparam int regAddrWidth = 5;

    // word-addressed memories
    localparam int imemDepth     = 64;
    localparam int imemAddrWidth = 6;
    localparam int dmemDepth     = 64;
    localparam int dmemAddrWidth = 6;

endpackage

/* rtl/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                progValid,
    output logic                                progReady,
    input  logic[cpuCfgPkg::imemAddrWidth-1:0]  progAddr,
    input  logic[cpuCfgPkg::dataWidth-1:0]      progData,
    input  logic                                start,
    output logic                                halted,
    input  logic[cpuCfgPkg::regAddrWidth-1:0]   dbgAddr,
    output logic[cpuCfgPkg::dataWidth-1:0]      dbgData
);
    logic[cpuCfgPkg::imemAddrWidth-1:0] instrAddr;
    logic[cpuCfgPkg::dataWidth-1:0]     instrData;
    logic                               runEn;

    hazardIf hzBus ();

    programStore programStore_i (
        .clk       (clk),
        .reset     (reset),
        .progValid (progValid),
        .progReady (progReady),
        .progAddr  (progAddr),
        .progData  (progData),
        .start     (start),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .halted    (halted),
        .runEn     (runEn)
    );

    pipelineCore pipelineCore_i (
        .clk       (clk),
        .reset     (reset),
        .runEn     (runEn),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .halted    (halted),
        .dbgAddr   (dbgAddr),
        .dbgData   (dbgData),
        .hz        (hzBus.core)
    );

    hazardUnit hazardUnit_i (
        .hz (hzBus.hazard)
    );

endmodule

/* rtl/hazardIf.sv */
`timescale 1ns/1ps

interface hazardIf ();
    logic[cpuCfgPkg::regAddrWidth-1:0] rs1D, rs2D;
    logic[cpuCfgPkg::regAddrWidth-1:0] rs1E, rs2E, rdE;
    rvIsaPkg::resultSrc                resultSrcE;
    logic[cpuCfgPkg::regAddrWidth-1:0] rdM, rdW;
    logic                              regWriteM, regWriteW;
    logic                              pcSrcE;  // taken beq or jal in execute

    rvIsaPkg::fwdSel                   forwardAE, forwardBE;
    logic                              stallF, stallD;
    logic                              flushD, flushE;

    modport core (
        output rs1D, rs2D, rs1E, rs2E, rdE, resultSrcE,
        output rdM, regWriteM, rdW, regWriteW, pcSrcE,
        input  forwardAE, forwardBE, stallF, stallD, flushD, flushE
    );

    modport hazard (
        input  rs1D, rs2D, rs1E, rs2E, rdE, resultSrcE,
        input  rdM, regWriteM, rdW, regWriteW, pcSrcE,
        output forwardAE, forwardBE, stallF, stallD, flushD, flushE
    );

endinterface

/* rtl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    hazardIf.hazard hz
);
    logic lwStall;

    // memory stage is younger so it wins over writeback
    function automatic rvIsaPkg::fwdSel fwdFor(
        input logic[cpuCfgPkg::regAddrWidth-1:0] rs
    );
        if (rs == '0)
            return rvIsaPkg::fwdRegFile;  // x0 never forwarded
        else if (hz.regWriteM && rs == hz.rdM)
            return rvIsaPkg::fwdFromMem;
        else if (hz.regWriteW && rs == hz.rdW)
            return rvIsaPkg::fwdFromWb;
        else
            return rvIsaPkg::fwdRegFile;
    endfunction

    always_comb begin
        hz.forwardAE = fwdFor(hz.rs1E);
        hz.forwardBE = fwdFor(hz.rs2E);
    end

    // load in execute feeding the instruction in decode
    assign lwStall = hz.resultSrcE[0] && hz.rdE != '0
                     && (hz.rdE == hz.rs1D || hz.rdE == hz.rs2D);

    assign hz.stallF = lwStall;
    assign hz.stallD = lwStall;

    assign hz.flushD = hz.pcSrcE;
    assign hz.flushE = lwStall | hz.pcSrcE;  // bubble into execute

endmodule

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
    input  rvIsaPkg::instrWord              instr,
    output logic                            regWrite,
    output logic                            memWrite,
    output logic                            branch,
    output logic                            jump,
    output logic                            aluSrcImm,
    output rvIsaPkg::aluOp                  aluCtl,
    output rvIsaPkg::resultSrc              resSrc,
    output logic[cpuCfgPkg::dataWidth-1:0]  imm
);
    rvIsaPkg::aluOp arithCtl;
    logic           knownFunct;
    logic           subSel;

    // funct7 is only meaningful for register-register ops
    assign subSel = instr.rType.opcode == rvIsaPkg::opOp
                    && instr.rType.funct7 == rvIsaPkg::f7Sub;

    always_comb begin
        knownFunct = 1'b1;
        case (instr.rType.funct3)
            rvIsaPkg::f3AddSub: arithCtl = subSel ? rvIsaPkg::aluSub : rvIsaPkg::aluAdd;
            rvIsaPkg::f3Slt:    arithCtl = rvIsaPkg::aluSlt;
            rvIsaPkg::f3Or:     arithCtl = rvIsaPkg::aluOr;
            rvIsaPkg::f3And:    arithCtl = rvIsaPkg::aluAnd;
            default: begin
                arithCtl   = rvIsaPkg::aluAdd;
                knownFunct = 1'b0;
            end
        endcase
    end

    always_comb begin
        regWrite  = 1'b0;  // defaults form a bubble
        memWrite  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        aluSrcImm = 1'b0;
        aluCtl    = rvIsaPkg::aluAdd;
        resSrc    = rvIsaPkg::resAlu;
        imm       = '0;
        case (instr.rType.opcode)
            rvIsaPkg::opOp: begin
                regWrite = knownFunct;
                aluCtl   = arithCtl;
            end
            rvIsaPkg::opOpImm: begin
                regWrite  = knownFunct;
                aluSrcImm = 1'b1;
                aluCtl    = arithCtl;
                imm       = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            end
            rvIsaPkg::opLoad: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                resSrc    = rvIsaPkg::resMem;
                imm       = {{20{instr.iType.imm[11]}}, instr.iType.imm};
            end
            rvIsaPkg::opStore: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                imm       = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
            end
            rvIsaPkg::opBranch: begin
                branch = instr.bType.funct3 == rvIsaPkg::f3Beq;  // beq only
                aluCtl = rvIsaPkg::aluSub;
                imm    = {{20{instr.bType.imm12}}, instr.bType.imm11,
                          instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
            end
            rvIsaPkg::opJal: begin
                regWrite = 1'b1;
                jump     = 1'b1;
                resSrc   = rvIsaPkg::resPcPlus4;
                imm      = {{12{instr.jType.imm20}}, instr.jType.imm19to12,
                            instr.jType.imm11, instr.jType.imm10to1, 1'b0};
            end
            default: ;
        endcase
    end

endmodule

/* rtl/pipelineCore.sv */
`timescale 1ns/1ps

module pipelineCore (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                runEn,
    output logic[cpuCfgPkg::imemAddrWidth-1:0]  instrAddr,
    input  logic[cpuCfgPkg::dataWidth-1:0]      instrData,
    output logic                                halted,
    input  logic[cpuCfgPkg::regAddrWidth-1:0]   dbgAddr,
    output logic[cpuCfgPkg::dataWidth-1:0]      dbgData,
    hazardIf.core                               hz
);
    logic[cpuCfgPkg::dataWidth-1:0] pcF, pcPlus4F, pcNextF;

    rvIsaPkg::instrWord             instrD;
    logic[cpuCfgPkg::dataWidth-1:0] pcD, rd1D, rd2D, immD;
    logic                           validD, regWriteD, memWriteD, branchD, jumpD, aluSrcImmD;
    rvIsaPkg::aluOp                 aluCtlD;
    rvIsaPkg::resultSrc             resSrcD;

    logic[cpuCfgPkg::dataWidth-1:0] rd1E, rd2E, immE, pcE, pcPlus4E, pcTargetE;
    logic[cpuCfgPkg::dataWidth-1:0] srcAE, srcBE, writeDataE, aluResultE;
    logic                           regWriteE, memWriteE, branchE, jumpE, aluSrcImmE, zeroE;
    rvIsaPkg::aluOp                 aluCtlE;

    logic[cpuCfgPkg::dataWidth-1:0] aluResultM, writeDataM, pcPlus4M, readDataM;
    logic                           memWriteM;
    rvIsaPkg::resultSrc             resultSrcM;

    logic[cpuCfgPkg::dataWidth-1:0] aluResultW, readDataW, pcPlus4W, resultW;
    rvIsaPkg::resultSrc             resultSrcW;

    logic[cpuCfgPkg::dataWidth-1:0] dmem[cpuCfgPkg::dmemDepth];

    // fetch
    assign pcPlus4F  = pcF + 32'd4;
    assign pcNextF   = hz.pcSrcE ? pcTargetE : pcPlus4F;
    assign instrAddr = pcF[cpuCfgPkg::imemAddrWidth+1:2];

    always_ff @(posedge clk) begin
        if (reset || !runEn)
            pcF <= '0;
        else if (!hz.stallF)
            pcF <= pcNextF;
    end

    always_ff @(posedge clk) begin
        if (reset || !runEn || hz.flushD)
            validD <= 1'b0;
        else if (!hz.stallD)
            validD <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!hz.stallD) begin
            instrD <= instrData;
            pcD    <= pcF;
        end
    end

    // decode
    assign hz.rs1D = validD ? instrD.rType.rs1 : '0;
    assign hz.rs2D = validD ? instrD.rType.rs2 : '0;

    instrDecoder instrDecoder_i (
        .instr     (instrD),
        .regWrite  (regWriteD),
        .memWrite  (memWriteD),
        .branch    (branchD),
        .jump      (jumpD),
        .aluSrcImm (aluSrcImmD),
        .aluCtl    (aluCtlD),
        .resSrc    (resSrcD),
        .imm       (immD)
    );

    regFile regFile_i (
        .clk     (clk),
        .reset   (reset),
        .ra1     (instrD.rType.rs1),
        .ra2     (instrD.rType.rs2),
        .rd1     (rd1D),
        .rd2     (rd2D),
        .wa      (hz.rdW),
        .wd      (resultW),
        .we      (hz.regWriteW),
        .dbgAddr (dbgAddr),
        .dbgData (dbgData)
    );

    always_ff @(posedge clk) begin
        if (reset || !runEn || hz.flushE) begin
            regWriteE     <= 1'b0;
            memWriteE     <= 1'b0;
            branchE       <= 1'b0;
            jumpE         <= 1'b0;
            hz.resultSrcE <= rvIsaPkg::resAlu;
        end else begin
            regWriteE     <= regWriteD & validD;
            memWriteE     <= memWriteD & validD;
            branchE       <= branchD & validD;
            jumpE         <= jumpD & validD;
            hz.resultSrcE <= validD ? resSrcD : rvIsaPkg::resAlu;
        end
    end

    always_ff @(posedge clk) begin
        aluCtlE    <= aluCtlD;
        aluSrcImmE <= aluSrcImmD;
        rd1E       <= rd1D;
        rd2E       <= rd2D;
        immE       <= immD;
        pcE        <= pcD;
        hz.rs1E    <= instrD.rType.rs1;
        hz.rs2E    <= instrD.rType.rs2;
        hz.rdE     <= instrD.rType.rd;
    end

    // execute, operand bypass
    always_comb begin
        case (hz.forwardAE)
            rvIsaPkg::fwdFromWb:  srcAE = resultW;
            rvIsaPkg::fwdFromMem: srcAE = aluResultM;
            default:              srcAE = rd1E;
        endcase
        case (hz.forwardBE)
            rvIsaPkg::fwdFromWb:  writeDataE = resultW;
            rvIsaPkg::fwdFromMem: writeDataE = aluResultM;
            default:              writeDataE = rd2E;
        endcase
    end

    assign srcBE = aluSrcImmE ? immE : writeDataE;

    aluUnit aluUnit_i (
        .a    (srcAE),
        .b    (srcBE),
        .ctl  (aluCtlE),
        .y    (aluResultE),
        .zero (zeroE)
    );

    assign pcTargetE = pcE + immE;
    assign pcPlus4E  = pcE + 32'd4;
    assign hz.pcSrcE = (branchE & zeroE) | jumpE;

    // jal to itself ends the run, sticky until reset
    always_ff @(posedge clk) begin
        if (reset)
            halted <= 1'b0;
        else if (jumpE && immE == '0)
            halted <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset || !runEn) begin
            hz.regWriteM <= 1'b0;
            memWriteM    <= 1'b0;
            resultSrcM   <= rvIsaPkg::resAlu;
        end else begin
            hz.regWriteM <= regWriteE;
            memWriteM    <= memWriteE;
            resultSrcM   <= hz.resultSrcE;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
        hz.rdM     <= hz.rdE;
    end

    // data memory, word addressed
    assign readDataM = dmem[aluResultM[cpuCfgPkg::dmemAddrWidth+1:2]];

    always_ff @(posedge clk) begin
        if (memWriteM)
            dmem[aluResultM[cpuCfgPkg::dmemAddrWidth+1:2]] <= writeDataM;
    end

    always_ff @(posedge clk) begin
        if (reset || !runEn) begin
            hz.regWriteW <= 1'b0;
            resultSrcW   <= rvIsaPkg::resAlu;
        end else begin
            hz.regWriteW <= hz.regWriteM;
            resultSrcW   <= resultSrcM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultW <= aluResultM;
        readDataW  <= readDataM;
        pcPlus4W   <= pcPlus4M;
        hz.rdW     <= hz.rdM;
    end

    // writeback select
    always_comb begin
        case (resultSrcW)
            rvIsaPkg::resMem:     resultW = readDataW;
            rvIsaPkg::resPcPlus4: resultW = pcPlus4W;
            default:              resultW = aluResultW;
        endcase
    end

endmodule

/* rtl/programStore.sv */
`timescale 1ns/1ps

module programStore (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                progValid,
    output logic                                progReady,
    input  logic[cpuCfgPkg::imemAddrWidth-1:0]  progAddr,
    input  logic[cpuCfgPkg::dataWidth-1:0]      progData,
    input  logic                                start,
    input  logic[cpuCfgPkg::imemAddrWidth-1:0]  instrAddr,
    output logic[cpuCfgPkg::dataWidth-1:0]      instrData,
    input  logic                                halted,
    output logic                                runEn
);
    logic[cpuCfgPkg::dataWidth-1:0] imem[cpuCfgPkg::imemDepth];

    // writes only while the core is idle
    assign progReady = !runEn;
    assign instrData = imem[instrAddr];

    always_ff @(posedge clk) begin
        if (progValid && progReady)
            imem[progAddr] <= progData;
    end

    // run bit, halt wins over a late start
    always_ff @(posedge clk) begin
        if (reset || halted)
            runEn <= 1'b0;
        else if (start)
            runEn <= 1'b1;
    end

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic[cpuCfgPkg::regAddrWidth-1:0]   ra1,
    input  logic[cpuCfgPkg::regAddrWidth-1:0]   ra2,
    output logic[cpuCfgPkg::dataWidth-1:0]      rd1,
    output logic[cpuCfgPkg::dataWidth-1:0]      rd2,
    input  logic[cpuCfgPkg::regAddrWidth-1:0]   wa,
    input  logic[cpuCfgPkg::dataWidth-1:0]      wd,
    input  logic                                we,
    input  logic[cpuCfgPkg::regAddrWidth-1:0]   dbgAddr,
    output logic[cpuCfgPkg::dataWidth-1:0]      dbgData
);
    logic[cpuCfgPkg::dataWidth-1:0] regs[cpuCfgPkg::regCount];

    // falling edge write, decode reads the new value in the same cycle
    always_ff @(negedge clk) begin
        if (reset) begin
            for (int i = 0; i < cpuCfgPkg::regCount; i++)
                regs[i] <= '0;
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1     = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2     = (ra2 == '0) ? '0 : regs[ra2];
    assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

/* rtl/rvIsaPkg.sv */
package rvIsaPkg;

    // base opcodes, instr[6:0]
    localparam logic[6:0] opOp     = 7'b0110011;
    localparam logic[6:0] opOpImm  = 7'b0010011;
    localparam logic[6:0] opLoad   = 7'b0000011;
    localparam logic[6:0] opStore  = 7'b0100011;
    localparam logic[6:0] opBranch = 7'b1100011;
    localparam logic[6:0] opJal    = 7'b1101111;

    localparam logic[2:0] f3AddSub = 3'b000;
    localparam logic[2:0] f3Slt    = 3'b010;
    localparam logic[2:0] f3Or     = 3'b110;
    localparam logic[2:0] f3And    = 3'b111;
    localparam logic[2:0] f3Beq    = 3'b000;
    localparam logic[6:0] f7Sub    = 7'b0100000;

    typedef enum logic[2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp;

    // bit 0 set means the result comes from a load
    typedef enum logic[1:0] {
        resAlu     = 2'b00,
        resMem     = 2'b01,
        resPcPlus4 = 2'b10
    } resultSrc;

    typedef enum logic[1:0] {
        fwdRegFile = 2'b00,
        fwdFromWb  = 2'b01,
        fwdFromMem = 2'b10
    } fwdSel;

    typedef union packed {
        struct packed {
            logic[6:0] funct7;
            logic[4:0] rs2;
            logic[4:0] rs1;
            logic[2:0] funct3;
            logic[4:0] rd;
            logic[6:0] opcode;
        } rType;
        struct packed {
            logic[11:0] imm;
            logic[4:0]  rs1;
            logic[2:0]  funct3;
            logic[4:0]  rd;
            logic[6:0]  opcode;
        } iType;
        struct packed {
            logic[6:0] immHi;
            logic[4:0] rs2;
            logic[4:0] rs1;
            logic[2:0] funct3;
            logic[4:0] immLo;
            logic[6:0] opcode;
        } sType;
        struct packed {
            logic      imm12;
            logic[5:0] imm10to5;
            logic[4:0] rs2;
            logic[4:0] rs1;
            logic[2:0] funct3;
            logic[3:0] imm4to1;
            logic      imm11;
            logic[6:0] opcode;
        } bType;
        struct packed {
            logic      imm20;
            logic[9:0] imm10to1;
            logic      imm11;
            logic[7:0] imm19to12;
            logic[4:0] rd;
            logic[6:0] opcode;
        } jType;
    } instrWord;

endpackage
